/* dv/exu_input.txt */
# pc inst rs1_value rs2_value opa_sel opb_sel alu_func cond uncond tag alu_result take_branch
# all hex, store_data and out_tag are expected to echo rs2_value and tag
00000040 00000033 00000005 00000003 0 0 0 0 0 01 00000008 0
00000040 00000033 7fffffff 00000001 0 0 0 0 0 02 80000000 0
00000040 00000033 ffffffff 00000001 0 0 0 0 0 03 00000000 0
00000040 00000033 00000003 00000005 0 0 1 0 0 04 fffffffe 0
00000040 00000033 80000000 00000001 0 0 1 0 0 05 7fffffff 0
00000040 00000033 f0f0f0f0 0ff00ff0 0 0 2 0 0 06 00f000f0 0
00000040 00000033 f0f0f0f0 0ff00ff0 0 0 3 0 0 07 fff0fff0 0
00000040 00000033 f0f0f0f0 0ff00ff0 0 0 4 0 0 08 ff00ff00 0
00000040 00000033 80000000 00000001 0 0 5 0 0 09 00000001 0
00000040 00000033 80000000 00000001 0 0 6 0 0 0a 00000000 0
00000040 00000033 ffffffff 00000000 0 0 5 0 0 0b 00000001 0
00000040 00000033 ffffffff 00000000 0 0 6 0 0 0c 00000000 0
00000040 00000033 00000000 ffffffff 0 0 6 0 0 0d 00000001 0
00000040 00000033 00000001 80000000 0 0 5 0 0 0e 00000000 0
00000040 00000033 00000001 00000021 0 0 7 0 0 0f 00000002 0
00000040 00000033 12345678 ffffffe4 0 0 7 0 0 10 23456780 0
00000040 00000033 80000000 0000003f 0 0 8 0 0 11 00000001 0
00000040 00000033 f0000000 00000104 0 0 8 0 0 12 0f000000 0
00000040 00000033 80000000 00000024 0 0 9 0 0 13 f8000000 0
00000040 00000033 f0000000 0000001c 0 0 9 0 0 14 ffffffff 0
00000040 00000033 70000000 0000003c 0 0 9 0 0 15 00000007 0
00000040 02000033 00000007 fffffffd 0 0 a 0 0 16 ffffffeb 0
00000040 02000033 00000007 fffffffd 0 0 b 0 0 17 ffffffff 0
00000040 02000033 00000007 fffffffd 0 0 d 0 0 18 00000006 0
00000040 02000033 fffffffd 00000007 0 0 c 0 0 19 ffffffff 0
00000040 02000033 00000007 fffffffd 0 0 c 0 0 1a 00000006 0
00000040 02000033 7fffffff 7fffffff 0 0 a 0 0 1b 00000001 0
00000040 02000033 7fffffff 7fffffff 0 0 b 0 0 1c 3fffffff 0
00000040 02000033 ffffffff ffffffff 0 0 d 0 0 1d fffffffe 0
00000040 02000033 80000000 80000000 0 0 b 0 0 1e 40000000 0
00000040 02000033 ffffffff ffffffff 0 0 b 0 0 1f 00000000 0
00000040 02000033 ffffffff ffffffff 0 0 c 0 0 20 ffffffff 0
00000040 02000033 00012345 00001000 0 0 a 0 0 21 12345000 0
00000040 12345037 00000000 00000000 3 4 0 0 0 22 12345000 0
00000040 fffff0b7 00000000 00000000 3 4 0 0 0 23 fffff000 0
00001000 00002017 00000000 00000000 1 4 0 0 0 24 00003000 0
00002ffc 0000006f 00000000 00000000 2 0 0 0 0 25 00003000 0
00000040 fff00013 00000010 00000000 0 1 0 0 0 26 0000000f 0
00000040 7ff00013 00000001 00000000 0 1 0 0 0 27 00000800 0
00000040 80000013 00001000 00000000 0 1 0 0 0 28 00000800 0
00000040 fe002e23 00001010 cafef00d 0 2 0 0 0 29 0000100c 0
00000040 02002223 00000100 12345678 0 2 0 0 0 2a 00000124 0
00000100 00000863 00000005 00000005 1 3 0 1 0 2b 00000110 1
00000100 00000863 00000005 00000006 1 3 0 1 0 2c 00000110 0
00000100 00001863 00000005 00000006 1 3 0 1 0 2d 00000110 1
00000100 00001863 00000005 00000005 1 3 0 1 0 2e 00000110 0
00000100 00004863 ffffffff 00000001 1 3 0 1 0 2f 00000110 1
00000100 00004863 00000001 ffffffff 1 3 0 1 0 30 00000110 0
00000100 00005863 00000001 ffffffff 1 3 0 1 0 31 00000110 1
00000100 00005863 80000000 7fffffff 1 3 0 1 0 32 00000110 0
00000100 00006863 00000001 ffffffff 1 3 0 1 0 33 00000110 1
00000100 00006863 ffffffff 00000001 1 3 0 1 0 34 00000110 0
00000100 00007863 ffffffff 00000001 1 3 0 1 0 35 00000110 1
00000100 00007863 00000000 00000001 1 3 0 1 0 36 00000110 0
00000100 00002863 00000005 00000005 1 3 0 1 0 37 00000110 0
00000100 00003863 00000001 00000002 1 3 0 1 0 38 00000110 0
00000200 fe000ce3 00000007 00000007 1 3 0 1 0 39 000001f8 1
00003000 0010006f 00000000 00000000 1 5 0 0 1 3a 00003800 1
00003000 ffdff06f 00000000 00000000 1 5 0 0 1 3b 00002ffc 1
00003000 00808067 00004000 00000000 0 1 0 0 1 3c 00004008 1

/* dv/exu_props.sv */
`timescale 1ns/100ps

// handshake and reset checks, bound into exu_top
module exu_props (
	input logic                      clock,
	input logic                      reset,
	input logic                      in_valid,
	input logic                      in_ready,
	input logic                      issue_valid,
	input logic                      out_valid,
	input logic                      out_ready,
	input logic [exu_pkg::xlen-1:0]  alu_result,
	input logic                      take_branch,
	input logic [exu_pkg::xlen-1:0]  store_data,
	input logic [exu_pkg::tag_w-1:0] out_tag
);
	// stalled result may not move
	property result_held;
		@(posedge clock) disable iff (reset)
			out_valid && !out_ready |=> out_valid && $stable(alu_result)
				&& $stable(take_branch) && $stable(store_data) && $stable(out_tag);
	endproperty

	property ready_when_draining;
		@(posedge clock) disable iff (reset)
			in_valid && out_ready |-> in_ready;
	endproperty

	// issue blocked only with both stages full
	property stall_means_full;
		@(posedge clock) disable iff (reset)
			in_valid && !in_ready |-> issue_valid && out_valid && !out_ready;
	endproperty

	property empty_after_reset;
		@(posedge clock) reset |=> !out_valid && !issue_valid && in_ready;
	endproperty

	a_result_held: assert property (result_held)
		else $error("result changed while out_ready was low");
	a_ready_when_draining: assert property (ready_when_draining)
		else $error("in_ready low although out_ready was high");
	a_stall_means_full: assert property (stall_means_full)
		else $error("in_ready low with a free stage");
	a_empty_after_reset: assert property (empty_after_reset)
		else $error("pipeline not empty after reset");

endmodule

/* dv/exu_tb.sv */
`timescale 1ns/100ps

module exu_tb;

	// one line of the vector file
	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] inst;
		logic [31:0] rs1;
		logic [31:0] rs2;
		logic [1:0]  asel;
		logic [2:0]  bsel;
		logic [3:0]  func;
		logic        cond;
		logic        uncond;
		logic [5:0]  tag;
		logic [31:0] exp_result;
		logic        exp_take;
	} vector_t;

	logic                      clock;
	logic                      reset;
	logic                      in_valid;
	logic                      in_ready;
	logic [exu_pkg::xlen-1:0]  pc;
	logic [exu_pkg::xlen-1:0]  inst;
	logic [exu_pkg::xlen-1:0]  rs1_value;
	logic [exu_pkg::xlen-1:0]  rs2_value;
	exu_pkg::opa_sel_t         opa_sel;
	exu_pkg::opb_sel_t         opb_sel;
	exu_pkg::alu_func_t        alu_func;
	logic                      cond_branch;
	logic                      uncond_branch;
	logic [exu_pkg::tag_w-1:0] tag;
	logic                      out_valid;
	logic                      out_ready;
	logic [exu_pkg::xlen-1:0]  alu_result;
	logic                      take_branch;
	logic [exu_pkg::xlen-1:0]  store_data;
	logic [exu_pkg::tag_w-1:0] out_tag;

	vector_t     vec_q[$];
	vector_t     exp_q[$];  // issued but result not yet seen
	logic [31:0] lfsr = 32'ha2b60cc3;
	int          cycles = 0;
	int          cycle_limit = 100;
	int          sent;
	int          done;
	logic        accepted_last;

	exu_top i_dut (
		.clock         (clock),
		.reset         (reset),
		.in_valid      (in_valid),
		.in_ready      (in_ready),
		.pc            (pc),
		.inst          (inst),
		.rs1_value     (rs1_value),
		.rs2_value     (rs2_value),
		.opa_sel       (opa_sel),
		.opb_sel       (opb_sel),
		.alu_func      (alu_func),
		.cond_branch   (cond_branch),
		.uncond_branch (uncond_branch),
		.tag           (tag),
		.out_valid     (out_valid),
		.out_ready     (out_ready),
		.alu_result    (alu_result),
		.take_branch   (take_branch),
		.store_data    (store_data),
		.out_tag       (out_tag)
	);

	bind exu_top exu_props i_props (
		.clock       (clock),
		.reset       (reset),
		.in_valid    (in_valid),
		.in_ready    (in_ready),
		.issue_valid (issue_valid),
		.out_valid   (out_valid),
		.out_ready   (out_ready),
		.alu_result  (alu_result),
		.take_branch (take_branch),
		.store_data  (store_data),
		.out_tag     (out_tag)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// galois form with taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {1'b0, s[31:1]} ^ (s[0] ? 32'h80200003 : 32'h0);
	endfunction

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("** FAIL **");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_value(input string field, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			abort_run($sformatf("Fail at time %0t: %s is %h, expected %h",
				$time, field, actual, expected));
		end
	endtask

	task automatic load_vectors();
		int          fd;
		int          n;
		string       line;
		logic [31:0] f [0:11];
		vector_t     v;
		fd = $fopen("dv/exu_input.txt", "r");
		if (fd == 0) abort_run("cannot open dv/exu_input.txt");
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 1 && line.getc(0) != "#") begin  // skip blanks and column notes
				n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
					f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11]);
				if (n != 12) abort_run({"malformed line in vector file: ", line});
				v.pc         = f[0];
				v.inst       = f[1];
				v.rs1        = f[2];
				v.rs2        = f[3];
				v.asel       = f[4][1:0];
				v.bsel       = f[5][2:0];
				v.func       = f[6][3:0];
				v.cond       = f[7][0];
				v.uncond     = f[8][0];
				v.tag        = f[9][5:0];
				v.exp_result = f[10];
				v.exp_take   = f[11][0];
				vec_q.push_back(v);
			end
		end
		$fclose(fd);
		if (vec_q.size() == 0) abort_run("vector file holds no vectors");
		cycle_limit = 20 * vec_q.size() + 100;
	endtask

	task automatic drive_issue(input vector_t v);
		pc            = v.pc;
		inst          = v.inst;
		rs1_value     = v.rs1;
		rs2_value     = v.rs2;
		opa_sel       = exu_pkg::opa_sel_t'(v.asel);
		opb_sel       = exu_pkg::opb_sel_t'(v.bsel);
		alu_func      = exu_pkg::alu_func_t'(v.func);
		cond_branch   = v.cond;
		uncond_branch = v.uncond;
		tag           = v.tag;
	endtask

	// oldest outstanding issue must match what leaves now
	task automatic compare_result();
		vector_t e;
		if (exp_q.size() == 0) abort_run("result transfer with no instruction outstanding");
		e = exp_q.pop_front();
		check_value("out_tag", {26'b0, out_tag}, {26'b0, e.tag});
		check_value("alu_result", alu_result, e.exp_result);
		check_value("take_branch", {31'b0, take_branch}, {31'b0, e.exp_take});
		check_value("store_data", store_data, e.rs2);
	endtask

	always @(posedge clock) begin
		cycles = cycles + 1;
		if (cycles > cycle_limit) begin
			abort_run($sformatf("timeout after %0d cycles with results still missing", cycles));
		end
	end

	initial begin
		reset         = 1'b1;
		in_valid      = 1'b0;
		out_ready     = 1'b0;
		pc            = '0;
		inst          = '0;
		rs1_value     = '0;
		rs2_value     = '0;
		opa_sel       = exu_pkg::opa_rs1;
		opb_sel       = exu_pkg::opb_rs2;
		alu_func      = exu_pkg::alu_add;
		cond_branch   = 1'b0;
		uncond_branch = 1'b0;
		tag           = '0;
		sent          = 0;
		done          = 0;
		accepted_last = 1'b0;
		load_vectors();
		repeat (2) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		while (done < vec_q.size()) begin
			if (sent < vec_q.size()) begin
				drive_issue(vec_q[sent]);  // same vector again while stalled
				in_valid = 1'b1;
			end else begin
				in_valid = 1'b0;
			end
			out_ready = lfsr[0];
			lfsr = lfsr_next(lfsr);
			#1;
			// handshakes seen here complete at the next rising edge
			if (out_ready) check_value("in_ready", {31'b0, in_ready}, 32'd1);
			// with two in flight the older sits in the result stage
			// a lone item gets there one edge after acceptance
			check_value("out_valid", {31'b0, out_valid},
				{31'b0, exp_q.size() > 1 || (exp_q.size() == 1 && !accepted_last)});
			accepted_last = in_valid && in_ready;
			if (accepted_last) begin
				exp_q.push_back(vec_q[sent]);
				sent = sent + 1;
			end
			if (out_valid && out_ready) begin
				compare_result();
				done = done + 1;
			end
			@(negedge clock);
		end
		in_valid  = 1'b0;
		out_ready = 1'b1;
		repeat (3) begin
			@(negedge clock);
			check_value("out_valid after last result", {31'b0, out_valid}, 32'd0);
		end
		$display("** PASS **");
		$finish;
	end

endmodule

/* run.sh */
#!/bin/bash
# build and run the exu testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f vlog.f --top-module exu_tb -o exu_sim --Mdir obj_dir
./obj_dir/exu_sim

/* src/alu.sv */
`timescale 1ns/100ps

// purely combinational RV32IM integer ALU
module alu (
	input  logic [exu_pkg::xlen-1:0] opa,
	input  logic [exu_pkg::xlen-1:0] opb,
	input  exu_pkg::alu_func_t       func,
	output logic [exu_pkg::xlen-1:0] result
);
	localparam int w = exu_pkg::xlen;

	// shows up only for an undefined func code
	localparam logic [w-1:0] func_marker = 32'hfacebeec;

	logic [4:0]     shamt;
	logic           lt_signed;
	logic           lt_unsigned;
	logic [2*w-1:0] opa_sx;
	logic [2*w-1:0] opa_zx;
	logic [2*w-1:0] opb_sx;
	logic [2*w-1:0] opb_zx;
	logic [2*w-1:0] mul_ss;
	logic [2*w-1:0] mul_su;
	logic [2*w-1:0] mul_uu;

	assign shamt       = opb[4:0];  // upper bits ignored
	assign lt_signed   = $signed(opa) < $signed(opb);
	assign lt_unsigned = opa < opb;

	// widen to 64 bits, the low 64 bits of the product are then exact
	assign opa_sx = {{w{opa[w-1]}}, opa};
	assign opa_zx = {{w{1'b0}}, opa};
	assign opb_sx = {{w{opb[w-1]}}, opb};
	assign opb_zx = {{w{1'b0}}, opb};

	assign mul_ss = opa_sx * opb_sx;
	assign mul_su = opa_sx * opb_zx;
	assign mul_uu = opa_zx * opb_zx;

	always_comb begin
		case (func)
			exu_pkg::alu_add:    result = opa + opb;
			exu_pkg::alu_sub:    result = opa - opb;
			exu_pkg::alu_and:    result = opa & opb;
			exu_pkg::alu_or:     result = opa | opb;
			exu_pkg::alu_xor:    result = opa ^ opb;
			exu_pkg::alu_slt:    result = {{(w-1){1'b0}}, lt_signed};
			exu_pkg::alu_sltu:   result = {{(w-1){1'b0}}, lt_unsigned};
			exu_pkg::alu_sll:    result = opa << shamt;
			exu_pkg::alu_srl:    result = opa >> shamt;
			exu_pkg::alu_sra:    result = $unsigned($signed(opa) >>> shamt);  // sign fill
			exu_pkg::alu_mul:    result = mul_ss[w-1:0];
			exu_pkg::alu_mulh:   result = mul_ss[2*w-1:w];
			exu_pkg::alu_mulhsu: result = mul_su[2*w-1:w];
			exu_pkg::alu_mulhu:  result = mul_uu[2*w-1:w];
			default:             result = func_marker;
		endcase
	end

endmodule

/* src/branch_unit.sv */
`timescale 1ns/100ps

module branch_unit (
	input  logic [exu_pkg::xlen-1:0] rs1_value,
	input  logic [exu_pkg::xlen-1:0] rs2_value,
	input  logic [2:0]               funct3,
	input  logic                     cond_branch,
	input  logic                     uncond_branch,
	output logic                     take_branch
);
	logic cond_true;
	logic eq;
	logic lt_signed;
	logic lt_unsigned;

	assign eq          = rs1_value == rs2_value;
	assign lt_signed   = $signed(rs1_value) < $signed(rs2_value);
	assign lt_unsigned = rs1_value < rs2_value;

	always_comb begin
		case (funct3)
			3'b000:  cond_true = eq;            // beq
			3'b001:  cond_true = !eq;           // bne
			3'b100:  cond_true = lt_signed;     // blt
			3'b101:  cond_true = !lt_signed;    // bge
			3'b110:  cond_true = lt_unsigned;   // bltu
			3'b111:  cond_true = !lt_unsigned;  // bgeu
			default: cond_true = 1'b0;          // 010, 011 never taken
		endcase
	end

	// jumps always go, branches only on a true condition
	assign take_branch = uncond_branch || (cond_branch && cond_true);

endmodule

/* src/exu_pkg.sv */
package exu_pkg;

	// datapath width, fixed by the RV32 encoding
	parameter int xlen = 32;

	// reorder buffer tag width
	parameter int tag_w = 6;

	// ALU operation codes
	typedef enum logic [3:0] {
		alu_add    = 4'd0,
		alu_sub    = 4'd1,
		alu_and    = 4'd2,
		alu_or     = 4'd3,
		alu_xor    = 4'd4,
		alu_slt    = 4'd5,
		alu_sltu   = 4'd6,
		alu_sll    = 4'd7,
		alu_srl    = 4'd8,
		alu_sra    = 4'd9,
		alu_mul    = 4'd10,
		alu_mulh   = 4'd11,  // signed x signed, high word
		alu_mulhsu = 4'd12,  // signed x unsigned, high word
		alu_mulhu  = 4'd13   // unsigned x unsigned, high word
	} alu_func_t;

	// operand A source
	typedef enum logic [1:0] {
		opa_rs1  = 2'd0,
		opa_pc   = 2'd1,
		opa_npc  = 2'd2,  // pc + 4, link address
		opa_zero = 2'd3
	} opa_sel_t;

	// operand B source, codes 6 and 7 unused
	typedef enum logic [2:0] {
		opb_rs2   = 3'd0,
		opb_i_imm = 3'd1,
		opb_s_imm = 3'd2,
		opb_b_imm = 3'd3,
		opb_u_imm = 3'd4,
		opb_j_imm = 3'd5
	} opb_sel_t;

	// instruction as issued by the reservation station
	typedef struct packed {
		logic [xlen-1:0]  pc;
		logic [xlen-1:0]  inst;
		logic [xlen-1:0]  rs1_value;
		logic [xlen-1:0]  rs2_value;
		opa_sel_t         opa_sel;
		opb_sel_t         opb_sel;
		alu_func_t        alu_func;
		logic             cond_branch;
		logic             uncond_branch;
		logic [tag_w-1:0] tag;
	} issue_t;

	// result headed for the common data bus
	typedef struct packed {
		logic [xlen-1:0]  alu_result;   // also the branch target
		logic             take_branch;
		logic [xlen-1:0]  rs2_value;    // store data
		logic [tag_w-1:0] tag;
	} result_t;

endpackage

/* src/exu_top.sv */
`timescale 1ns/100ps

// integer execution unit, issue register then result register
module exu_top (
	input  logic                      clock,
	input  logic                      reset,

	input  logic                      in_valid,
	output logic                      in_ready,
	input  logic [exu_pkg::xlen-1:0]  pc,
	input  logic [exu_pkg::xlen-1:0]  inst,
	input  logic [exu_pkg::xlen-1:0]  rs1_value,
	input  logic [exu_pkg::xlen-1:0]  rs2_value,
	input  exu_pkg::opa_sel_t         opa_sel,
	input  exu_pkg::opb_sel_t         opb_sel,
	input  exu_pkg::alu_func_t        alu_func,
	input  logic                      cond_branch,
	input  logic                      uncond_branch,
	input  logic [exu_pkg::tag_w-1:0] tag,

	output logic                      out_valid,
	input  logic                      out_ready,
	output logic [exu_pkg::xlen-1:0]  alu_result,
	output logic                      take_branch,
	output logic [exu_pkg::xlen-1:0]  store_data,
	output logic [exu_pkg::tag_w-1:0] out_tag
);
	exu_pkg::issue_t  issue_d;
	exu_pkg::issue_t  issue_q;
	exu_pkg::result_t result_d;
	exu_pkg::result_t result_q;

	logic                     issue_valid;
	logic                     result_ready;
	logic [exu_pkg::xlen-1:0] opa;
	logic [exu_pkg::xlen-1:0] opb;

	assign issue_d.pc            = pc;
	assign issue_d.inst          = inst;
	assign issue_d.rs1_value     = rs1_value;
	assign issue_d.rs2_value     = rs2_value;
	assign issue_d.opa_sel       = opa_sel;
	assign issue_d.opb_sel       = opb_sel;
	assign issue_d.alu_func      = alu_func;
	assign issue_d.cond_branch   = cond_branch;
	assign issue_d.uncond_branch = uncond_branch;
	assign issue_d.tag           = tag;

	pipe_stage #(.payload_t(exu_pkg::issue_t)) i_issue_stage (
		.clock     (clock),
		.reset     (reset),
		.in_valid  (in_valid),
		.in_data   (issue_d),
		.in_ready  (in_ready),
		.out_valid (issue_valid),
		.out_data  (issue_q),
		.out_ready (result_ready)
	);

	operand_select i_operand_select (
		.pc        (issue_q.pc),
		.inst      (issue_q.inst),
		.rs1_value (issue_q.rs1_value),
		.rs2_value (issue_q.rs2_value),
		.opa_sel   (issue_q.opa_sel),
		.opb_sel   (issue_q.opb_sel),
		.opa       (opa),
		.opb       (opb)
	);

	// branch target comes out here too, pc + b_imm or j_imm
	alu i_alu (
		.opa    (opa),
		.opb    (opb),
		.func   (issue_q.alu_func),
		.result (result_d.alu_result)
	);

	branch_unit i_branch_unit (
		.rs1_value     (issue_q.rs1_value),
		.rs2_value     (issue_q.rs2_value),
		.funct3        (issue_q.inst[14:12]),
		.cond_branch   (issue_q.cond_branch),
		.uncond_branch (issue_q.uncond_branch),
		.take_branch   (result_d.take_branch)
	);

	assign result_d.rs2_value = issue_q.rs2_value;
	assign result_d.tag       = issue_q.tag;

	pipe_stage #(.payload_t(exu_pkg::result_t)) i_result_stage (
		.clock     (clock),
		.reset     (reset),
		.in_valid  (issue_valid),
		.in_data   (result_d),
		.in_ready  (result_ready),
		.out_valid (out_valid),
		.out_data  (result_q),
		.out_ready (out_ready)
	);

	assign alu_result  = result_q.alu_result;
	assign take_branch = result_q.take_branch;
	assign store_data  = result_q.rs2_value;
	assign out_tag     = result_q.tag;

endmodule

/* src/operand_select.sv */
`timescale 1ns/100ps

module operand_select (
	input  logic [exu_pkg::xlen-1:0] pc,
	input  logic [exu_pkg::xlen-1:0] inst,
	input  logic [exu_pkg::xlen-1:0] rs1_value,
	input  logic [exu_pkg::xlen-1:0] rs2_value,
	input  exu_pkg::opa_sel_t        opa_sel,
	input  exu_pkg::opb_sel_t        opb_sel,
	output logic [exu_pkg::xlen-1:0] opa,
	output logic [exu_pkg::xlen-1:0] opb
);
	// seen on opb only for a bad select code
	localparam logic [exu_pkg::xlen-1:0] opb_marker = 32'hfacefeed;

	logic [exu_pkg::xlen-1:0] npc;
	logic [exu_pkg::xlen-1:0] i_imm;
	logic [exu_pkg::xlen-1:0] s_imm;
	logic [exu_pkg::xlen-1:0] b_imm;
	logic [exu_pkg::xlen-1:0] u_imm;
	logic [exu_pkg::xlen-1:0] j_imm;

	assign npc = pc + 32'd4;

	// RV32 immediates sign extended from inst[31]
	assign i_imm = {{20{inst[31]}}, inst[31:20]};
	assign s_imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign b_imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign u_imm = {inst[31:12], 12'b0};
	assign j_imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		case (opa_sel)
			exu_pkg::opa_rs1: opa = rs1_value;
			exu_pkg::opa_pc:  opa = pc;
			exu_pkg::opa_npc: opa = npc;
			default:          opa = '0;  // opa_zero, lui
		endcase
	end

	always_comb begin
		opb = opb_marker;
		case (opb_sel)
			exu_pkg::opb_rs2:   opb = rs2_value;
			exu_pkg::opb_i_imm: opb = i_imm;
			exu_pkg::opb_s_imm: opb = s_imm;
			exu_pkg::opb_b_imm: opb = b_imm;
			exu_pkg::opb_u_imm: opb = u_imm;
			exu_pkg::opb_j_imm: opb = j_imm;
			default:            opb = opb_marker;
		endcase
	end

endmodule

/* src/pipe_stage.sv */
`timescale 1ns/100ps

// single register slice, full throughput when downstream is ready
module pipe_stage #(
	parameter type payload_t = logic [31:0]
) (
	input  logic     clock,
	input  logic     reset,

	input  logic     in_valid,
	input  payload_t in_data,
	output logic     in_ready,

	output logic     out_valid,
	output payload_t out_data,
	input  logic     out_ready
);
	logic accept;

	// free slot, or the held item leaves this cycle
	assign in_ready = !out_valid || out_ready;
	assign accept   = in_valid && in_ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (in_ready) begin
			out_valid <= in_valid;  // refill or drain
		end
	end

	// payload only moves on a transfer in
	always_ff @(posedge clock) begin
		if (accept) begin
			out_data <= in_data;
		end
	end

endmodule

/* vlog.f */
src/exu_pkg.sv
src/pipe_stage.sv
src/operand_select.sv
src/alu.sv
src/branch_unit.sv
src/exu_top.sv
dv/exu_props.sv
dv/exu_tb.sv
